/* Makefile */
VERILATOR := verilator
TOP       := tb_lane
FILELIST  := build.f
VFLAGS    := --binary --assert --timing --timescale 1ns/1ns -Wno-fatal
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Everything OK

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* build.f */
src/lane_cfg_pkg.sv
src/lane_isa_pkg.sv
src/vector_regfile.sv
src/vrf_arbiter.sv
src/lane_sequencer.sv
src/operand_requester.sv
src/lane_alu.sv
src/lane_top.sv
verification/tb_lane.sv

/* src/lane_alu.sv */
// Lane ALU, buffers operand pairs, computes one result per element and writes it back to vd
`timescale 1ns/1ns

module lane_alu (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Sequencer
  input  logic                                  insn_start_i,
  input  logic [lane_isa_pkg::OpWidth-1:0]      op_i,
  input  logic [lane_cfg_pkg::VRegIdxWidth-1:0] vd_i,
  input  logic [lane_cfg_pkg::VlWidth-1:0]      vl_i,
  // Operand requester
  input  logic                                  opnd_valid_i,
  input  logic [lane_cfg_pkg::ElemWidth-1:0]    opnd_a_i,
  input  logic [lane_cfg_pkg::ElemWidth-1:0]    opnd_b_i,
  // Write-back port
  output logic                                  wb_req_o,
  output logic [lane_cfg_pkg::VaddrWidth-1:0]   wb_addr_o,
  output logic [lane_cfg_pkg::ElemWidth-1:0]    wb_wdata_o,
  input  logic                                  wb_gnt_i,
  // Credits and completion
  output logic                                  credit_return_o,
  output logic                                  insn_done_o
);

  logic [lane_cfg_pkg::ElemWidth-1:0]              a_mem [lane_cfg_pkg::AluFifoDepth];
  logic [lane_cfg_pkg::ElemWidth-1:0]              b_mem [lane_cfg_pkg::AluFifoDepth];
  logic [$clog2(lane_cfg_pkg::AluFifoDepth)-1:0]   wr_ptr_q;
  logic [$clog2(lane_cfg_pkg::AluFifoDepth)-1:0]   rd_ptr_q;
  logic [$clog2(lane_cfg_pkg::AluFifoDepth+1)-1:0] cnt_q;
  logic [lane_cfg_pkg::ElemIdxWidth-1:0]           elem_q;
  logic                                            done_q;
  logic [lane_cfg_pkg::ElemWidth-1:0]              head_a;
  logic [lane_cfg_pkg::ElemWidth-1:0]              head_b;

  ////////////////////
  // Operand FIFO
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (opnd_valid_i) begin
      a_mem[wr_ptr_q] <= opnd_a_i;
      b_mem[wr_ptr_q] <= opnd_b_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      elem_q   <= '0;
      done_q   <= 1'b0;
    end else begin
      wr_ptr_q <= wr_ptr_q + opnd_valid_i;
      rd_ptr_q <= rd_ptr_q + wb_gnt_i;
      cnt_q    <= cnt_q + opnd_valid_i - wb_gnt_i;
      done_q   <= wb_gnt_i && ({1'b0, elem_q} == vl_i - 1'b1);
      if (insn_start_i) begin
        elem_q <= '0;
      end else if (wb_gnt_i) begin
        elem_q <= elem_q + 1'b1;
      end
    end
  end

  assign head_a = a_mem[rd_ptr_q];
  assign head_b = b_mem[rd_ptr_q];

  always_comb begin
    case (op_i)
      lane_isa_pkg::OpAdd: wb_wdata_o = head_a + head_b;
      lane_isa_pkg::OpSub: wb_wdata_o = head_a - head_b;
      lane_isa_pkg::OpAnd: wb_wdata_o = head_a & head_b;
      lane_isa_pkg::OpOr:  wb_wdata_o = head_a | head_b;
      lane_isa_pkg::OpXor: wb_wdata_o = head_a ^ head_b;
      default:             wb_wdata_o = '0;
    endcase
  end

  assign wb_req_o        = (cnt_q != '0);
  assign wb_addr_o       = {vd_i, elem_q};
  assign credit_return_o = wb_gnt_i;
  assign insn_done_o     = done_q;

  // Credits upstream keep the buffer from filling past its depth
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    opnd_valid_i && !wb_gnt_i |-> cnt_q < lane_cfg_pkg::AluFifoDepth);

endmodule

/* src/lane_cfg_pkg.sv */
// Sizes of the lane datapath and register file, referenced by scoped name from the lane RTL
package lane_cfg_pkg;

  ////////////////////
  // Datapath
  ////////////////////

  localparam int unsigned ElemWidth = 32;

  // Register file geometry
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned VRegIdxWidth = 3;
  localparam int unsigned MaxVl        = 16;
  // Holds vl from 1 to MaxVl
  localparam int unsigned VlWidth      = 5;
  localparam int unsigned ElemIdxWidth = 4;
  // Word address is vreg * MaxVl + element
  localparam int unsigned VaddrWidth   = 7;

  // Operand pairs buffered ahead of the ALU
  localparam int unsigned AluFifoDepth = 4;

  ////////////////////
  // Port arbitration
  ////////////////////

  localparam int unsigned NrVrfPeers = 4;
  // Index order is priority order, 0 wins
  localparam int unsigned PeerAluWb  = 0;
  localparam int unsigned PeerLdu    = 1;
  localparam int unsigned PeerStu    = 2;
  localparam int unsigned PeerOpreq  = 3;

endpackage

/* src/lane_isa_pkg.sv */
// Opcode encodings and source-field layout of a lane instruction, shared by sequencer and ALU
package lane_isa_pkg;

  ////////////////////
  // Opcodes
  ////////////////////

  localparam int unsigned OpWidth = 3;

  localparam logic [OpWidth-1:0] OpAdd = 3'd0;
  localparam logic [OpWidth-1:0] OpSub = 3'd1;
  localparam logic [OpWidth-1:0] OpAnd = 3'd2;
  localparam logic [OpWidth-1:0] OpOr  = 3'd3;
  localparam logic [OpWidth-1:0] OpXor = 3'd4;

  ////////////////////
  // Source field
  ////////////////////

  localparam int unsigned SrcWidth = 16;

  // Same 16 bits seen as a register index or as a signed immediate
  typedef union packed {
    struct packed {
      logic [SrcWidth-lane_cfg_pkg::VRegIdxWidth-1:0] unused;
      logic [lane_cfg_pkg::VRegIdxWidth-1:0]          vs1;
    } vreg;
    // Sign-extended to ElemWidth where it is used
    logic signed [SrcWidth-1:0] scalar;
  } lane_src_u;

endpackage

/* src/lane_sequencer.sv */
// Accepts one lane instruction at a time and holds it for the units until the ALU is done
`timescale 1ns/1ns

module lane_sequencer (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Instruction request
  input  logic                                    pe_req_valid_i,
  output logic                                    pe_req_ready_o,
  input  logic [lane_isa_pkg::OpWidth-1:0]        pe_req_op_i,
  input  logic [lane_cfg_pkg::VRegIdxWidth-1:0]   pe_req_vd_i,
  input  logic [lane_cfg_pkg::VRegIdxWidth-1:0]   pe_req_vs2_i,
  input  logic                                    pe_req_scalar_i,
  input  lane_isa_pkg::lane_src_u                 pe_req_src_i,
  input  logic [lane_cfg_pkg::VlWidth-1:0]        pe_req_vl_i,
  output logic                                    alu_vinsn_done_o,
  // Operand requester
  output logic                                    insn_start_o,
  output logic [lane_cfg_pkg::VRegIdxWidth-1:0]   vs2_o,
  output logic [lane_cfg_pkg::VRegIdxWidth-1:0]   vs1_o,
  output logic                                    scalar_flag_o,
  output logic [lane_cfg_pkg::ElemWidth-1:0]      scalar_o,
  output logic [lane_cfg_pkg::VlWidth-1:0]        vl_o,
  // ALU
  output logic [lane_isa_pkg::OpWidth-1:0]        op_o,
  output logic [lane_cfg_pkg::VRegIdxWidth-1:0]   vd_o,
  input  logic                                    insn_done_i
);

  logic                    busy_q;
  logic                    start_q;
  logic                    accept;
  lane_isa_pkg::lane_src_u src_q;

  assign pe_req_ready_o = !busy_q;
  assign accept         = pe_req_valid_i && pe_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (insn_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Held instruction fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_o          <= pe_req_op_i;
      vd_o          <= pe_req_vd_i;
      vs2_o         <= pe_req_vs2_i;
      scalar_flag_o <= pe_req_scalar_i;
      src_q         <= pe_req_src_i;
      vl_o          <= pe_req_vl_i;
    end
  end

  ////////////////////
  // Source decode
  ////////////////////

  assign vs1_o    = src_q.vreg.vs1;
  assign scalar_o = {{(lane_cfg_pkg::ElemWidth - lane_isa_pkg::SrcWidth){src_q.scalar[
                     lane_isa_pkg::SrcWidth-1]}}, src_q.scalar};

  assign insn_start_o     = start_q;
  assign alu_vinsn_done_o = insn_done_i;

  // Done only for a held instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_done_i |-> busy_q && !start_q);
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> pe_req_vl_i >= 1 && pe_req_vl_i <= lane_cfg_pkg::MaxVl);

endmodule

/* src/lane_top.sv */
// Top of the vector lane, connects sequencer, operand requester, ALU, port arbiter and register file
`timescale 1ns/1ns

module lane_top (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Instruction request
  input  logic                                  pe_req_valid_i,
  output logic                                  pe_req_ready_o,
  input  logic [lane_isa_pkg::OpWidth-1:0]      pe_req_op_i,
  input  logic [lane_cfg_pkg::VRegIdxWidth-1:0] pe_req_vd_i,
  input  logic [lane_cfg_pkg::VRegIdxWidth-1:0] pe_req_vs2_i,
  input  logic                                  pe_req_scalar_i,
  input  lane_isa_pkg::lane_src_u               pe_req_src_i,
  input  logic [lane_cfg_pkg::VlWidth-1:0]      pe_req_vl_i,
  output logic                                  alu_vinsn_done_o,
  // Load port
  input  logic                                  ldu_result_req_i,
  input  logic [lane_cfg_pkg::VaddrWidth-1:0]   ldu_result_addr_i,
  input  logic [lane_cfg_pkg::ElemWidth-1:0]    ldu_result_wdata_i,
  output logic                                  ldu_result_gnt_o,
  // Store port
  input  logic                                  stu_req_i,
  input  logic [lane_cfg_pkg::VaddrWidth-1:0]   stu_addr_i,
  output logic                                  stu_gnt_o,
  output logic [lane_cfg_pkg::ElemWidth-1:0]    stu_rdata_o,
  output logic                                  stu_rvalid_o
);

  // Sequencer fan-out
  logic                                  insn_start, insn_done, scalar_flag;
  logic [lane_cfg_pkg::VRegIdxWidth-1:0] vs2, vs1, vd;
  logic [lane_cfg_pkg::ElemWidth-1:0]    scalar;
  logic [lane_cfg_pkg::VlWidth-1:0]      vl;
  logic [lane_isa_pkg::OpWidth-1:0]      op;
  // Operand pairs and credits
  logic                                  opnd_valid, credit_return;
  logic [lane_cfg_pkg::ElemWidth-1:0]    opnd_a, opnd_b;
  // Arbiter slots
  logic [lane_cfg_pkg::NrVrfPeers-1:0]                               vrf_req, vrf_wen;
  logic [lane_cfg_pkg::NrVrfPeers-1:0]                               vrf_gnt, vrf_rvalid;
  logic [lane_cfg_pkg::NrVrfPeers-1:0][lane_cfg_pkg::VaddrWidth-1:0] vrf_addr;
  logic [lane_cfg_pkg::NrVrfPeers-1:0][lane_cfg_pkg::ElemWidth-1:0]  vrf_wdata;
  logic                                  mem_en, mem_wen;
  logic [lane_cfg_pkg::VaddrWidth-1:0]   mem_addr;
  logic [lane_cfg_pkg::ElemWidth-1:0]    mem_wdata, mem_rdata;

  ////////////////////
  // Peer slots
  ////////////////////

  assign vrf_wen[lane_cfg_pkg::PeerAluWb]   = 1'b1;
  assign vrf_req[lane_cfg_pkg::PeerLdu]     = ldu_result_req_i;
  assign vrf_addr[lane_cfg_pkg::PeerLdu]    = ldu_result_addr_i;
  assign vrf_wen[lane_cfg_pkg::PeerLdu]     = 1'b1;
  assign vrf_wdata[lane_cfg_pkg::PeerLdu]   = ldu_result_wdata_i;
  assign vrf_req[lane_cfg_pkg::PeerStu]     = stu_req_i;
  assign vrf_addr[lane_cfg_pkg::PeerStu]    = stu_addr_i;
  assign vrf_wen[lane_cfg_pkg::PeerStu]     = 1'b0;
  assign vrf_wdata[lane_cfg_pkg::PeerStu]   = '0;
  assign vrf_wen[lane_cfg_pkg::PeerOpreq]   = 1'b0;
  assign vrf_wdata[lane_cfg_pkg::PeerOpreq] = '0;

  assign ldu_result_gnt_o = vrf_gnt[lane_cfg_pkg::PeerLdu];
  assign stu_gnt_o        = vrf_gnt[lane_cfg_pkg::PeerStu];
  assign stu_rvalid_o     = vrf_rvalid[lane_cfg_pkg::PeerStu];
  assign stu_rdata_o      = mem_rdata;

  lane_sequencer i_lane_sequencer (
    .clk_i, .rst_ni, .pe_req_valid_i, .pe_req_ready_o, .pe_req_op_i, .pe_req_vd_i,
    .pe_req_vs2_i, .pe_req_scalar_i, .pe_req_src_i, .pe_req_vl_i, .alu_vinsn_done_o,
    .insn_start_o (insn_start),
    .vs2_o        (vs2),
    .vs1_o        (vs1),
    .scalar_flag_o(scalar_flag),
    .scalar_o     (scalar),
    .vl_o         (vl),
    .op_o         (op),
    .vd_o         (vd),
    .insn_done_i  (insn_done)
  );

  operand_requester i_operand_requester (
    .clk_i, .rst_ni,
    .insn_start_i   (insn_start),
    .vs2_i          (vs2),
    .vs1_i          (vs1),
    .scalar_flag_i  (scalar_flag),
    .scalar_i       (scalar),
    .vl_i           (vl),
    .vrf_req_o      (vrf_req[lane_cfg_pkg::PeerOpreq]),
    .vrf_addr_o     (vrf_addr[lane_cfg_pkg::PeerOpreq]),
    .vrf_gnt_i      (vrf_gnt[lane_cfg_pkg::PeerOpreq]),
    .vrf_rdata_i    (mem_rdata),
    .vrf_rvalid_i   (vrf_rvalid[lane_cfg_pkg::PeerOpreq]),
    .opnd_valid_o   (opnd_valid),
    .opnd_a_o       (opnd_a),
    .opnd_b_o       (opnd_b),
    .credit_return_i(credit_return)
  );

  lane_alu i_lane_alu (
    .clk_i, .rst_ni,
    .insn_start_i   (insn_start),
    .op_i           (op),
    .vd_i           (vd),
    .vl_i           (vl),
    .opnd_valid_i   (opnd_valid),
    .opnd_a_i       (opnd_a),
    .opnd_b_i       (opnd_b),
    .wb_req_o       (vrf_req[lane_cfg_pkg::PeerAluWb]),
    .wb_addr_o      (vrf_addr[lane_cfg_pkg::PeerAluWb]),
    .wb_wdata_o     (vrf_wdata[lane_cfg_pkg::PeerAluWb]),
    .wb_gnt_i       (vrf_gnt[lane_cfg_pkg::PeerAluWb]),
    .credit_return_o(credit_return),
    .insn_done_o    (insn_done)
  );

  vrf_arbiter i_vrf_arbiter (
    .clk_i, .rst_ni,
    .req_i      (vrf_req),
    .addr_i     (vrf_addr),
    .wen_i      (vrf_wen),
    .wdata_i    (vrf_wdata),
    .gnt_o      (vrf_gnt),
    .rvalid_o   (vrf_rvalid),
    .mem_en_o   (mem_en),
    .mem_addr_o (mem_addr),
    .mem_wen_o  (mem_wen),
    .mem_wdata_o(mem_wdata)
  );

  vector_regfile i_vrf (
    .clk_i, .rst_ni,
    .en_i   (mem_en),
    .addr_i (mem_addr),
    .wen_i  (mem_wen),
    .wdata_i(mem_wdata),
    .rdata_o(mem_rdata)
  );

endmodule

/* src/operand_requester.sv */
// Operand requester, reads vs2 and vs1 elements of the running instruction and feeds pairs to the ALU
`timescale 1ns/1ns

module operand_requester (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Sequencer
  input  logic                                    insn_start_i,
  input  logic [lane_cfg_pkg::VRegIdxWidth-1:0]   vs2_i,
  input  logic [lane_cfg_pkg::VRegIdxWidth-1:0]   vs1_i,
  input  logic                                    scalar_flag_i,
  input  logic [lane_cfg_pkg::ElemWidth-1:0]      scalar_i,
  input  logic [lane_cfg_pkg::VlWidth-1:0]        vl_i,
  // Register file port
  output logic                                    vrf_req_o,
  output logic [lane_cfg_pkg::VaddrWidth-1:0]     vrf_addr_o,
  input  logic                                    vrf_gnt_i,
  input  logic [lane_cfg_pkg::ElemWidth-1:0]      vrf_rdata_i,
  input  logic                                    vrf_rvalid_i,
  // ALU
  output logic                                    opnd_valid_o,
  output logic [lane_cfg_pkg::ElemWidth-1:0]      opnd_a_o,
  output logic [lane_cfg_pkg::ElemWidth-1:0]      opnd_b_o,
  input  logic                                    credit_return_i
);

  logic                                          active_q;
  // Low while fetching vs2, high while fetching vs1
  logic                                          phase_b_q;
  logic [lane_cfg_pkg::ElemIdxWidth-1:0]         elem_q;
  logic [$clog2(lane_cfg_pkg::AluFifoDepth+1)-1:0] credit_q;
  logic                                          rd_b_q;
  logic [lane_cfg_pkg::ElemWidth-1:0]            a_q;
  logic                                          last_elem;
  logic                                          take_credit;

  assign last_elem   = ({1'b0, elem_q} == vl_i - 1'b1);
  assign take_credit = vrf_gnt_i && !phase_b_q;

  // A new element only starts when the ALU has room for its pair
  assign vrf_req_o  = active_q && (phase_b_q || credit_q != '0);
  assign vrf_addr_o = {phase_b_q ? vs1_i : vs2_i, elem_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q  <= 1'b0;
      phase_b_q <= 1'b0;
      elem_q    <= '0;
      rd_b_q    <= 1'b0;
      credit_q  <= ($bits(credit_q))'(lane_cfg_pkg::AluFifoDepth);
    end else begin
      rd_b_q   <= vrf_gnt_i && phase_b_q;
      credit_q <= credit_q - take_credit + credit_return_i;
      if (insn_start_i) begin
        active_q  <= 1'b1;
        phase_b_q <= 1'b0;
        elem_q    <= '0;
      end else if (vrf_gnt_i) begin
        phase_b_q <= !phase_b_q && !scalar_flag_i;
        // Element complete after vs2 alone or after vs1
        if (phase_b_q || scalar_flag_i) begin
          if (last_elem) begin
            active_q <= 1'b0;
          end else begin
            elem_q <= elem_q + 1'b1;
          end
        end
      end
    end
  end

  // vs2 element waits here for its vs1 partner
  always_ff @(posedge clk_i) begin
    if (vrf_rvalid_i && !rd_b_q) begin
      a_q <= vrf_rdata_i;
    end
  end

  assign opnd_valid_o = vrf_rvalid_i && (rd_b_q || scalar_flag_i);
  assign opnd_a_o     = rd_b_q ? a_q : vrf_rdata_i;
  assign opnd_b_o     = rd_b_q ? vrf_rdata_i : scalar_i;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= lane_cfg_pkg::AluFifoDepth);

endmodule

/* src/vector_regfile.sv */
// Single-port lane register file, written in the grant cycle and read with one cycle of latency
`timescale 1ns/1ns

module vector_regfile (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                en_i,
  input  logic [lane_cfg_pkg::VaddrWidth-1:0] addr_i,
  input  logic                                wen_i,
  input  logic [lane_cfg_pkg::ElemWidth-1:0]  wdata_i,
  output logic [lane_cfg_pkg::ElemWidth-1:0]  rdata_o
);

  ////////////////////
  // Storage
  ////////////////////

  logic [lane_cfg_pkg::ElemWidth-1:0] mem_q [lane_cfg_pkg::NrVRegs*lane_cfg_pkg::MaxVl];

  always_ff @(posedge clk_i) begin
    if (en_i && wen_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // Registered read port
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (en_i && !wen_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

/* src/vrf_arbiter.sv */
// Fixed-priority arbiter giving the single register file port to one of the lane peers per cycle
`timescale 1ns/1ns

module vrf_arbiter (
  input  logic                                                         clk_i,
  input  logic                                                         rst_ni,
  // Peers
  input  logic [lane_cfg_pkg::NrVrfPeers-1:0]                          req_i,
  input  logic [lane_cfg_pkg::NrVrfPeers-1:0][lane_cfg_pkg::VaddrWidth-1:0] addr_i,
  input  logic [lane_cfg_pkg::NrVrfPeers-1:0]                          wen_i,
  input  logic [lane_cfg_pkg::NrVrfPeers-1:0][lane_cfg_pkg::ElemWidth-1:0]  wdata_i,
  output logic [lane_cfg_pkg::NrVrfPeers-1:0]                          gnt_o,
  output logic [lane_cfg_pkg::NrVrfPeers-1:0]                          rvalid_o,
  // Register file
  output logic                                                         mem_en_o,
  output logic [lane_cfg_pkg::VaddrWidth-1:0]                          mem_addr_o,
  output logic                                                         mem_wen_o,
  output logic [lane_cfg_pkg::ElemWidth-1:0]                           mem_wdata_o
);

  logic [lane_cfg_pkg::NrVrfPeers-1:0] rd_gnt_q;

  // Lowest index wins
  always_comb begin
    logic taken;
    taken       = 1'b0;
    gnt_o       = '0;
    mem_addr_o  = '0;
    mem_wen_o   = 1'b0;
    mem_wdata_o = '0;
    for (int i = 0; i < lane_cfg_pkg::NrVrfPeers; i++) begin
      if (req_i[i] && !taken) begin
        taken       = 1'b1;
        gnt_o[i]    = 1'b1;
        mem_addr_o  = addr_i[i];
        mem_wen_o   = wen_i[i];
        mem_wdata_o = wdata_i[i];
      end
    end
  end

  assign mem_en_o = |req_i;

  // Read data comes back one cycle after the grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_gnt_q <= '0;
    end else begin
      rd_gnt_q <= gnt_o & ~wen_i;
    end
  end

  assign rvalid_o = rd_gnt_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_o) && $onehot0(rvalid_o));

endmodule

/* verification/tb_lane.sv */
// Self-checking testbench for the vector lane, simulated as top module over the lane RTL
`timescale 1ns/1ns

module tb_lane;

  localparam int unsigned TimeoutCycles = 300;
  localparam int unsigned NrInsns       = 40;
  localparam int unsigned NrWords       = lane_cfg_pkg::NrVRegs * lane_cfg_pkg::MaxVl;

  logic                                  clk_i;
  logic                                  rst_ni;
  logic                                  pe_req_valid_i;
  logic                                  pe_req_ready_o;
  logic [lane_isa_pkg::OpWidth-1:0]      pe_req_op_i;
  logic [lane_cfg_pkg::VRegIdxWidth-1:0] pe_req_vd_i;
  logic [lane_cfg_pkg::VRegIdxWidth-1:0] pe_req_vs2_i;
  logic                                  pe_req_scalar_i;
  lane_isa_pkg::lane_src_u               pe_req_src_i;
  logic [lane_cfg_pkg::VlWidth-1:0]      pe_req_vl_i;
  logic                                  alu_vinsn_done_o;
  logic                                  ldu_result_req_i;
  logic [lane_cfg_pkg::VaddrWidth-1:0]   ldu_result_addr_i;
  logic [lane_cfg_pkg::ElemWidth-1:0]    ldu_result_wdata_i;
  logic                                  ldu_result_gnt_o;
  logic                                  stu_req_i;
  logic [lane_cfg_pkg::VaddrWidth-1:0]   stu_addr_i;
  logic                                  stu_gnt_o;
  logic [lane_cfg_pkg::ElemWidth-1:0]    stu_rdata_o;
  logic                                  stu_rvalid_o;

  logic [31:0]                           lfsr_q;
  logic [lane_cfg_pkg::ElemWidth-1:0]    shadow [NrWords];
  logic [lane_cfg_pkg::ElemWidth-1:0]    shadow_word;
  logic [lane_cfg_pkg::ElemWidth-1:0]    exp_q;
  logic [lane_cfg_pkg::VaddrWidth-1:0]   exp_addr_q;
  logic                                  gnt_d_q;
  logic                                  pending_q;
  logic                                  idle_phase;
  int                                    errors;
  int                                    timeouts;
  int                                    accepts;
  int                                    dones;

  lane_top dut (.*);

  always #4 clk_i = ~clk_i;

  ////////////////////
  // Stimulus helpers
  ////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned k = 0; k < n; k++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return val;
  endfunction

  function automatic logic [lane_cfg_pkg::VaddrWidth-1:0] word_addr(
    input logic [lane_cfg_pkg::VRegIdxWidth-1:0] vreg, input int unsigned elem);
    return {vreg, elem[lane_cfg_pkg::ElemIdxWidth-1:0]};
  endfunction

  // Reference ALU
  function automatic logic [31:0] alu_model(input logic [2:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      lane_isa_pkg::OpAdd: return a + b;
      lane_isa_pkg::OpSub: return a - b;
      lane_isa_pkg::OpAnd: return a & b;
      lane_isa_pkg::OpOr:  return a | b;
      default:             return a ^ b;
    endcase
  endfunction

  task automatic load_word(input logic [lane_cfg_pkg::VaddrWidth-1:0] addr,
                           input logic [31:0] data);
    int cnt;
    idle_phase         = 1'b0;
    ldu_result_req_i   = 1'b1;
    ldu_result_addr_i  = addr;
    ldu_result_wdata_i = data;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!ldu_result_gnt_o && cnt < TimeoutCycles);
    if (!ldu_result_gnt_o) begin
      timeouts++;
      $display("Timeout: load to word %0d was never granted", addr);
    end
    @(posedge clk_i);
    #1;
    shadow[addr]     = data;
    ldu_result_req_i = 1'b0;
  endtask

  task automatic store_read(input logic [lane_cfg_pkg::VaddrWidth-1:0] addr);
    int cnt;
    stu_req_i  = 1'b1;
    stu_addr_i = addr;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!stu_gnt_o && cnt < TimeoutCycles);
    if (!stu_gnt_o) begin
      timeouts++;
      $display("Timeout: store read of word %0d was never granted", addr);
    end
    @(posedge clk_i);
    #1;
    stu_req_i = 1'b0;
  endtask

  task automatic run_insn(input int unsigned idx);
    logic [2:0]                            op;
    logic [lane_cfg_pkg::VRegIdxWidth-1:0] vd;
    logic [lane_cfg_pkg::VRegIdxWidth-1:0] vs2;
    logic [lane_cfg_pkg::VRegIdxWidth-1:0] r;
    logic                                  scalar;
    logic                                  hold;
    lane_isa_pkg::lane_src_u               src;
    logic [31:0]                           b;
    logic [31:0]                           result [lane_cfg_pkg::MaxVl];
    logic [lane_cfg_pkg::VaddrWidth-1:0]   st_addr [4];
    int unsigned                           vl;
    int unsigned                           n_st;
    int                                    cnt_a;
    // Sweep all opcodes in both forms first, then random
    op     = (idx < 10) ? 3'(idx % 5) : 3'(rand_bits(8) % 5);
    scalar = (idx < 10) ? (idx >= 5) : rand_bits(1);
    vd     = rand_bits(3);
    vs2    = rand_bits(3);
    vl     = rand_bits(4) + 1;
    hold   = rand_bits(1);
    src.scalar = rand_bits(16);
    // Operand values as they are before the instruction
    for (int unsigned i = 0; i < vl; i++) begin
      b = scalar ? {{16{src.scalar[15]}}, src.scalar} : shadow[word_addr(src.vreg.vs1, i)];
      result[i] = alu_model(op, shadow[word_addr(vs2, i)], b);
    end
    // Store reads while running, never to vd
    n_st = rand_bits(2);
    for (int unsigned s = 0; s < n_st; s++) begin
      r = rand_bits(3);
      if (r == vd) begin
        r = r + 1'b1;
      end
      st_addr[s] = word_addr(r, rand_bits(4));
    end

    pe_req_valid_i  = 1'b1;
    pe_req_op_i     = op;
    pe_req_vd_i     = vd;
    pe_req_vs2_i    = vs2;
    pe_req_scalar_i = scalar;
    pe_req_src_i    = src;
    pe_req_vl_i     = vl[lane_cfg_pkg::VlWidth-1:0];
    cnt_a = 0;
    do begin
      @(negedge clk_i);
      cnt_a++;
    end while (!pe_req_ready_o && cnt_a < TimeoutCycles);
    if (!pe_req_ready_o) begin
      timeouts++;
      $display("Timeout: instruction %0d was never accepted", idx);
      pe_req_valid_i = 1'b0;
      return;
    end
    @(posedge clk_i);
    #1;
    if (!hold) begin
      pe_req_valid_i = 1'b0;
    end

    fork
      begin
        cnt_a = 0;
        do begin
          @(negedge clk_i);
          cnt_a++;
        end while (!alu_vinsn_done_o && cnt_a < TimeoutCycles);
        if (!alu_vinsn_done_o) begin
          timeouts++;
          $display("Timeout: instruction %0d never signalled done", idx);
        end
        @(posedge clk_i);
        #1;
        pe_req_valid_i = 1'b0;
      end
      begin
        for (int unsigned s = 0; s < n_st; s++) begin
          store_read(st_addr[s]);
        end
      end
    join

    for (int unsigned i = 0; i < vl; i++) begin
      shadow[word_addr(vd, i)] = result[i];
    end
    // Whole register, so the tail above vl is checked too
    for (int unsigned e = 0; e < lane_cfg_pkg::MaxVl; e++) begin
      store_read(word_addr(vd, e));
    end
  endtask

  ////////////////////
  // Checkers
  ////////////////////

  assign shadow_word = shadow[stu_addr_i];

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_d_q    <= 1'b0;
      pending_q  <= 1'b0;
      exp_q      <= '0;
      exp_addr_q <= '0;
      accepts    <= 0;
      dones      <= 0;
    end else begin
      gnt_d_q    <= stu_gnt_o;
      exp_q      <= shadow_word;
      exp_addr_q <= stu_addr_i;
      if (pe_req_valid_i && pe_req_ready_o) begin
        pending_q <= 1'b1;
        accepts   <= accepts + 1;
      end else if (alu_vinsn_done_o) begin
        pending_q <= 1'b0;
      end
      if (alu_vinsn_done_o) begin
        dones <= dones + 1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_phase |-> pe_req_ready_o && !alu_vinsn_done_o && !ldu_result_gnt_o && !stu_gnt_o
                   && !stu_rvalid_o)
  else begin
    errors++;
    $display("MISMATCH at %0t: lane outputs not idle before the first request", $time);
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) stu_rvalid_o == gnt_d_q)
  else begin
    errors++;
    $display("MISMATCH at %0t: store rvalid %0b one cycle after grant %0b", $time,
             stu_rvalid_o, gnt_d_q);
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_d_q |-> stu_rdata_o == exp_q)
  else begin
    errors++;
    $display("MISMATCH at %0t: word %0d read %h, expected %h", $time, $sampled(exp_addr_q),
             stu_rdata_o, $sampled(exp_q));
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) alu_vinsn_done_o |-> pending_q)
  else begin
    errors++;
    $display("MISMATCH at %0t: done pulse with no instruction in flight", $time);
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) pending_q |-> !pe_req_ready_o)
  else begin
    errors++;
    $display("MISMATCH at %0t: ready high while an instruction runs", $time);
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    clk_i              = 1'b0;
    rst_ni             = 1'b0;
    pe_req_valid_i     = 1'b0;
    pe_req_op_i        = '0;
    pe_req_vd_i        = '0;
    pe_req_vs2_i       = '0;
    pe_req_scalar_i    = 1'b0;
    pe_req_src_i       = '0;
    pe_req_vl_i        = '0;
    ldu_result_req_i   = 1'b0;
    ldu_result_addr_i  = '0;
    ldu_result_wdata_i = '0;
    stu_req_i          = 1'b0;
    stu_addr_i         = '0;
    idle_phase         = 1'b1;
    lfsr_q             = 32'hb711;
    errors             = 0;
    timeouts           = 0;

    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;

    for (int unsigned a = 0; a < NrWords; a++) begin
      load_word(a[lane_cfg_pkg::VaddrWidth-1:0], rand_bits(32));
    end
    for (int unsigned a = 0; a < NrWords; a++) begin
      store_read(a[lane_cfg_pkg::VaddrWidth-1:0]);
    end
    for (int unsigned n = 0; n < NrInsns && timeouts == 0; n++) begin
      run_insn(n);
    end
    for (int unsigned a = 0; a < NrWords; a++) begin
      store_read(a[lane_cfg_pkg::VaddrWidth-1:0]);
    end
    repeat (4) @(posedge clk_i);
    #1;

    if (accepts != dones) begin
      errors++;
      $display("MISMATCH at %0t: %0d instructions accepted, %0d done pulses", $time,
               accepts, dones);
    end
    $display("Summary: %0d mismatches, %0d timeouts, %0d instructions", errors, timeouts,
             accepts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
